// ==== all.f ====
design/axi_rd_pkg.sv
design/axi_ar_if.sv
design/axi_r_if.sv
design/rd_arbiter.sv
design/ar_router.sv
design/r_router.sv
design/axi_rd_xbar.sv
tests/tb_clock.sv
tests/rd_slave_model.sv
tests/axi_rd_xbar_tb.sv

// ==== tests/axi_rd_xbar_tb.sv ====
//======================================================================
// Read crossbar testbench with stimulus, reference model,
// compare process, check task and watchdog
//======================================================================
`timescale 1ns/1ps

module axi_rd_xbar_tb;
	import axi_rd_pkg::*;

	localparam int RESET_CYCLES       = 5;
	localparam int RR_READS           = 4;
	localparam int ROUTE_READS        = 4;
	localparam int BURSTS_PER_MASTER  = 8;
	localparam int TOTAL_READS        = 2 * RR_READS + ROUTE_READS + 2 * BURSTS_PER_MASTER;
	localparam int CYCLES_PER_READ    = 200;

	// One read as issued by a master
	typedef struct packed {
		id_t                   id;
		addr_t                 addr;
		logic [LEN_BITS-1:0]   len;
		logic [SIZE_BITS-1:0]  size;
		logic [BURST_BITS-1:0] burst;
	} rd_req_t;

	// One beat as the master should see it
	typedef struct packed {
		id_t                  id;
		data_t                data;
		logic [RESP_BITS-1:0] resp;
		logic                 last;
	} beat_t;

	logic ACLK;
	logic ARESETn;

	// Master ports indexed by master number
	id_t                   arid_m    [2];
	addr_t                 araddr_m  [2];
	logic [LEN_BITS-1:0]   arlen_m   [2];
	logic [SIZE_BITS-1:0]  arsize_m  [2];
	logic [BURST_BITS-1:0] arburst_m [2];
	logic                  arvalid_m [2];
	logic                  arready_m [2];
	id_t                   rid_m     [2];
	data_t                 rdata_m   [2];
	logic [RESP_BITS-1:0]  rresp_m   [2];
	logic                  rlast_m   [2];
	logic                  rvalid_m  [2];
	logic                  rready_m  [2];

	// Slave ports indexed by slave number
	ids_t                  arid_s    [2];
	addr_t                 araddr_s  [2];
	logic [LEN_BITS-1:0]   arlen_s   [2];
	logic [SIZE_BITS-1:0]  arsize_s  [2];
	logic [BURST_BITS-1:0] arburst_s [2];
	logic                  arvalid_s [2];
	logic                  arready_s [2];
	ids_t                  rid_s     [2];
	data_t                 rdata_s   [2];
	logic [RESP_BITS-1:0]  rresp_s   [2];
	logic                  rlast_s   [2];
	logic                  rvalid_s  [2];
	logic                  rready_s  [2];

	// Read in flight as taken at the master address handshake
	logic    cur_m;
	rd_req_t cur_req;
	int      beat_cnt;
	int      reads_issued;
	int      reads_done;
	int      done_order [$];

	tb_clock #(.PERIOD_NS(20)) tb_clock_i (.clk(ACLK));

	axi_rd_xbar axi_rd_xbar_i (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.arid_m0    (arid_m[0]),
		.araddr_m0  (araddr_m[0]),
		.arlen_m0   (arlen_m[0]),
		.arsize_m0  (arsize_m[0]),
		.arburst_m0 (arburst_m[0]),
		.arvalid_m0 (arvalid_m[0]),
		.arready_m0 (arready_m[0]),
		.rid_m0     (rid_m[0]),
		.rdata_m0   (rdata_m[0]),
		.rresp_m0   (rresp_m[0]),
		.rlast_m0   (rlast_m[0]),
		.rvalid_m0  (rvalid_m[0]),
		.rready_m0  (rready_m[0]),
		.arid_m1    (arid_m[1]),
		.araddr_m1  (araddr_m[1]),
		.arlen_m1   (arlen_m[1]),
		.arsize_m1  (arsize_m[1]),
		.arburst_m1 (arburst_m[1]),
		.arvalid_m1 (arvalid_m[1]),
		.arready_m1 (arready_m[1]),
		.rid_m1     (rid_m[1]),
		.rdata_m1   (rdata_m[1]),
		.rresp_m1   (rresp_m[1]),
		.rlast_m1   (rlast_m[1]),
		.rvalid_m1  (rvalid_m[1]),
		.rready_m1  (rready_m[1]),
		.arid_s0    (arid_s[0]),
		.araddr_s0  (araddr_s[0]),
		.arlen_s0   (arlen_s[0]),
		.arsize_s0  (arsize_s[0]),
		.arburst_s0 (arburst_s[0]),
		.arvalid_s0 (arvalid_s[0]),
		.arready_s0 (arready_s[0]),
		.rid_s0     (rid_s[0]),
		.rdata_s0   (rdata_s[0]),
		.rresp_s0   (rresp_s[0]),
		.rlast_s0   (rlast_s[0]),
		.rvalid_s0  (rvalid_s[0]),
		.rready_s0  (rready_s[0]),
		.arid_s1    (arid_s[1]),
		.araddr_s1  (araddr_s[1]),
		.arlen_s1   (arlen_s[1]),
		.arsize_s1  (arsize_s[1]),
		.arburst_s1 (arburst_s[1]),
		.arvalid_s1 (arvalid_s[1]),
		.arready_s1 (arready_s[1]),
		.rid_s1     (rid_s[1]),
		.rdata_s1   (rdata_s[1]),
		.rresp_s1   (rresp_s[1]),
		.rlast_s1   (rlast_s[1]),
		.rvalid_s1  (rvalid_s[1]),
		.rready_s1  (rready_s[1])
	);

	for (genvar k = 0; k < 2; k++) begin : slaves
		rd_slave_model #(.SLAVE_IDX(k)) rd_slave_model_i (
			.ACLK    (ACLK),
			.ARESETn (ARESETn),
			.arid    (arid_s[k]),
			.araddr  (araddr_s[k]),
			.arlen   (arlen_s[k]),
			.arvalid (arvalid_s[k]),
			.arready (arready_s[k]),
			.rid     (rid_s[k]),
			.rdata   (rdata_s[k]),
			.rresp   (rresp_s[k]),
			.rlast   (rlast_s[k]),
			.rvalid  (rvalid_s[k]),
			.rready  (rready_s[k])
		);
	end

	//==================================================================
	// Reference model and checking
	//==================================================================

	// Slave picked by address bit 16 sets the data offset
	function automatic beat_t expected_beat(input rd_req_t req, input int beat);
		beat_t b;
		b.id   = req.id;
		b.data = req.addr + 4 * beat;
		b.data = b.data + (req.addr[SLAVE_SEL_BIT] ? 32'h2000_0000 : 32'h1000_0000);
		b.resp = req.addr[4] ? RESP_SLVERR : RESP_OKAY;
		b.last = (beat == req.len);
		return b;
	endfunction

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Run stopped on first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic expect_idle_outputs();
		int k;
		for (k = 0; k < 2; k++) begin
			check($sformatf("arready_m%0d", k), arready_m[k], 0);
			check($sformatf("rvalid_m%0d", k), rvalid_m[k], 0);
			check($sformatf("arvalid_s%0d", k), arvalid_s[k], 0);
		end
	endtask

	// All handshakes sampled on the rising edge
	always @(posedge ACLK) begin : compare
		int    k;
		int    m;
		beat_t want;
		if (ARESETn) begin
			// Only the decoded slave may see ARVALID
			for (k = 0; k < 2; k++) begin
				if (arvalid_s[k]) begin
					check($sformatf("slave index of arvalid_s%0d", k), k,
						cur_req.addr[SLAVE_SEL_BIT]);
					if (arready_s[k]) begin
						check($sformatf("arid_s%0d", k), arid_s[k],
							{3'b000, cur_m, cur_req.id});
						check($sformatf("araddr_s%0d", k), araddr_s[k], cur_req.addr);
						check($sformatf("arlen_s%0d", k), arlen_s[k], cur_req.len);
						check($sformatf("arsize_s%0d", k), arsize_s[k], cur_req.size);
						check($sformatf("arburst_s%0d", k), arburst_s[k], cur_req.burst);
					end
				end
			end
			// Master data beats
			for (m = 0; m < 2; m++) begin
				if (rvalid_m[m] && rready_m[m]) begin
					check($sformatf("master index of rvalid_m%0d", m), m, cur_m);
					want = expected_beat(cur_req, beat_cnt);
					check($sformatf("rid_m%0d", m), rid_m[m], want.id);
					check($sformatf("rdata_m%0d", m), rdata_m[m], want.data);
					check($sformatf("rresp_m%0d", m), rresp_m[m], want.resp);
					check($sformatf("rlast_m%0d", m), rlast_m[m], want.last);
					if (want.last) begin
						done_order.push_back(m);
						reads_done++;
						beat_cnt = 0;
					end else begin
						beat_cnt++;
					end
				end
			end
			// New read accepted from a master
			for (m = 0; m < 2; m++) begin
				if (arvalid_m[m] && arready_m[m]) begin
					cur_m         = m[0];
					cur_req.id    = arid_m[m];
					cur_req.addr  = araddr_m[m];
					cur_req.len   = arlen_m[m];
					cur_req.size  = arsize_m[m];
					cur_req.burst = arburst_m[m];
				end
			end
		end
	end

	//==================================================================
	// Stimulus
	//==================================================================

	// Random RREADY stalls about one cycle in four
	always @(negedge ACLK) begin
		if (ARESETn) begin
			rready_m[0] = ($urandom % 4) != 0;
			rready_m[1] = ($urandom % 4) != 0;
		end
	end

	// Starts and returns just after a falling edge
	task automatic issue_read(input int m, input id_t id, input addr_t addr,
		input logic [LEN_BITS-1:0] len);
		arid_m[m]    = id;
		araddr_m[m]  = addr;
		arlen_m[m]   = len;
		arsize_m[m]  = 3'($urandom % 3);
		arvalid_m[m] = 1'b1;
		reads_issued++;
		@(posedge ACLK);
		while (!arready_m[m]) @(posedge ACLK);
		@(negedge ACLK);
		arvalid_m[m] = 1'b0;
	endtask

	// Back to back requests keep the master pending
	task automatic contend_round_robin(input int m);
		int    i;
		addr_t addr;
		@(negedge ACLK);
		for (i = 0; i < RR_READS; i++) begin
			addr = 32'h0000_0400 * (m + 1) + 32'h10 * i;
			addr[SLAVE_SEL_BIT] = ((i + m) % 2) != 0;
			issue_read(m, id_t'(8 * m + i), addr, i % 4);
		end
	endtask

	// Single beats from every master to every slave
	task automatic route_single_beats();
		int    m;
		int    s;
		addr_t addr;
		@(negedge ACLK);
		for (m = 0; m < 2; m++) begin
			for (s = 0; s < 2; s++) begin
				addr = 32'h0000_3000 + 32'h100 * (2 * m + s);
				addr[SLAVE_SEL_BIT] = (s != 0);
				addr[4] = (m != s);
				issue_read(m, id_t'(12 + m + 2 * s), addr, 0);
			end
		end
	endtask

	task automatic stream_bursts(input int m);
		int    i;
		addr_t addr;
		@(negedge ACLK);
		for (i = 0; i < BURSTS_PER_MASTER; i++) begin
			addr = $urandom & 32'h0001_fffc;
			repeat ($urandom % 3) @(negedge ACLK);
			issue_read(m, id_t'($urandom), addr, $urandom % 8);
		end
	endtask

	task automatic wait_reads_done();
		wait (reads_done == reads_issued);
		@(negedge ACLK);
	endtask

	initial begin
		int seed;
		int i;
		seed = 12;
		void'($urandom(seed));
		ARESETn = 1'b0;
		cur_m = 1'b0;
		cur_req = '0;
		beat_cnt = 0;
		reads_issued = 0;
		reads_done = 0;
		for (i = 0; i < 2; i++) begin
			arid_m[i]    = '0;
			araddr_m[i]  = '0;
			arlen_m[i]   = '0;
			arsize_m[i]  = 3'd2;
			arburst_m[i] = 2'b01;
			arvalid_m[i] = 1'b0;
			rready_m[i]  = 1'b0;
		end

		// Outputs quiet during and right after reset
		repeat (RESET_CYCLES) begin
			@(negedge ACLK);
			expect_idle_outputs();
		end
		ARESETn = 1'b1;
		@(negedge ACLK);
		expect_idle_outputs();

		// Completions alternate starting with m0 while both masters wait
		fork
			contend_round_robin(0);
			contend_round_robin(1);
		join
		wait_reads_done();
		for (i = 0; i < 2 * RR_READS; i++) begin
			check($sformatf("master of completed read %0d", i), done_order[i], i % 2);
		end

		route_single_beats();
		wait_reads_done();

		fork
			stream_bursts(0);
			stream_bursts(1);
		join
		wait_reads_done();

		$display("TEST PASS");
		$finish;
	end

	// Watchdog over the whole run
	initial begin
		repeat (RESET_CYCLES + CYCLES_PER_READ * TOTAL_READS) @(posedge ACLK);
		$display("Timeout: reads did not complete, %0d of %0d done", reads_done, TOTAL_READS);
		abort_run();
	end

endmodule

// ==== tests/rd_slave_model.sv ====
//======================================================================
// Behavioral AXI read slave with random address and data stalls
//======================================================================
`timescale 1ns/1ps

module rd_slave_model #(
	parameter int SLAVE_IDX = 0
) (
	input  logic                             ACLK,
	input  logic                             ARESETn,
	input  axi_rd_pkg::ids_t                 arid,
	input  axi_rd_pkg::addr_t                araddr,
	input  logic [axi_rd_pkg::LEN_BITS-1:0]  arlen,
	input  logic                             arvalid,
	output logic                             arready,
	output axi_rd_pkg::ids_t                 rid,
	output axi_rd_pkg::data_t                rdata,
	output logic [axi_rd_pkg::RESP_BITS-1:0] rresp,
	output logic                             rlast,
	output logic                             rvalid,
	input  logic                             rready
);
	import axi_rd_pkg::*;

	// Request captured from the address channel
	ids_t                req_id;
	addr_t               req_addr;
	logic [LEN_BITS-1:0] req_len;

	// len+1 beats, random gaps of 0 to 2 cycles before each one
	task automatic send_burst();
		int beat;
		int gap;
		for (beat = 0; beat <= req_len; beat++) begin
			gap = $urandom % 3;
			if (gap != 0) begin
				rvalid = 1'b0;
				rlast  = 1'b0;
				repeat (gap) @(negedge ACLK);
			end
			rid    = req_id;
			rdata  = req_addr + 4 * beat + 32'h1000_0000 * (SLAVE_IDX + 1);
			rresp  = req_addr[4] ? RESP_SLVERR : RESP_OKAY;
			rlast  = (beat == req_len);
			rvalid = 1'b1;
			// Hold the beat until the crossbar takes it
			@(posedge ACLK);
			while (!rready) @(posedge ACLK);
			@(negedge ACLK);
		end
		rvalid = 1'b0;
		rlast  = 1'b0;
	endtask

	initial begin
		int delay;
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rid     = '0;
		rdata   = '0;
		rresp   = RESP_OKAY;
		@(posedge ARESETn);
		forever begin
			@(negedge ACLK);
			if (arvalid) begin
				req_id   = arid;
				req_addr = araddr;
				req_len  = arlen;
				// ARREADY after 0 to 3 cycles, valid stays up meanwhile
				delay = $urandom % 4;
				repeat (delay) @(negedge ACLK);
				arready = 1'b1;
				@(posedge ACLK);
				@(negedge ACLK);
				arready = 1'b0;
				send_burst();
			end
		end
	end

endmodule

// ==== tests/tb_clock.sv ====
//======================================================================
// Free-running testbench clock
//======================================================================
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	// Low at time zero, first rising edge half a period later
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

// ==== design/axi_rd_xbar.sv ====
//======================================================================
// Read crossbar top, 2 masters to 2 slaves, plain AXI ports
//======================================================================
`timescale 1ns/1ps

module axi_rd_xbar (
	input  logic                              ACLK,
	input  logic                              ARESETn,
	// Master 0
	input  axi_rd_pkg::id_t                   arid_m0,
	input  axi_rd_pkg::addr_t                 araddr_m0,
	input  logic [axi_rd_pkg::LEN_BITS-1:0]   arlen_m0,
	input  logic [axi_rd_pkg::SIZE_BITS-1:0]  arsize_m0,
	input  logic [axi_rd_pkg::BURST_BITS-1:0] arburst_m0,
	input  logic                              arvalid_m0,
	output logic                              arready_m0,
	output axi_rd_pkg::id_t                   rid_m0,
	output axi_rd_pkg::data_t                 rdata_m0,
	output logic [axi_rd_pkg::RESP_BITS-1:0]  rresp_m0,
	output logic                              rlast_m0,
	output logic                              rvalid_m0,
	input  logic                              rready_m0,
	// Master 1
	input  axi_rd_pkg::id_t                   arid_m1,
	input  axi_rd_pkg::addr_t                 araddr_m1,
	input  logic [axi_rd_pkg::LEN_BITS-1:0]   arlen_m1,
	input  logic [axi_rd_pkg::SIZE_BITS-1:0]  arsize_m1,
	input  logic [axi_rd_pkg::BURST_BITS-1:0] arburst_m1,
	input  logic                              arvalid_m1,
	output logic                              arready_m1,
	output axi_rd_pkg::id_t                   rid_m1,
	output axi_rd_pkg::data_t                 rdata_m1,
	output logic [axi_rd_pkg::RESP_BITS-1:0]  rresp_m1,
	output logic                              rlast_m1,
	output logic                              rvalid_m1,
	input  logic                              rready_m1,
	// Slave 0
	output axi_rd_pkg::ids_t                  arid_s0,
	output axi_rd_pkg::addr_t                 araddr_s0,
	output logic [axi_rd_pkg::LEN_BITS-1:0]   arlen_s0,
	output logic [axi_rd_pkg::SIZE_BITS-1:0]  arsize_s0,
	output logic [axi_rd_pkg::BURST_BITS-1:0] arburst_s0,
	output logic                              arvalid_s0,
	input  logic                              arready_s0,
	input  axi_rd_pkg::ids_t                  rid_s0,
	input  axi_rd_pkg::data_t                 rdata_s0,
	input  logic [axi_rd_pkg::RESP_BITS-1:0]  rresp_s0,
	input  logic                              rlast_s0,
	input  logic                              rvalid_s0,
	output logic                              rready_s0,
	// Slave 1
	output axi_rd_pkg::ids_t                  arid_s1,
	output axi_rd_pkg::addr_t                 araddr_s1,
	output logic [axi_rd_pkg::LEN_BITS-1:0]   arlen_s1,
	output logic [axi_rd_pkg::SIZE_BITS-1:0]  arsize_s1,
	output logic [axi_rd_pkg::BURST_BITS-1:0] arburst_s1,
	output logic                              arvalid_s1,
	input  logic                              arready_s1,
	input  axi_rd_pkg::ids_t                  rid_s1,
	input  axi_rd_pkg::data_t                 rdata_s1,
	input  logic [axi_rd_pkg::RESP_BITS-1:0]  rresp_s1,
	input  logic                              rlast_s1,
	input  logic                              rvalid_s1,
	output logic                              rready_s1
);
	import axi_rd_pkg::*;

	rd_state_e state;
	logic      grant;
	logic      route;
	logic      addr_accept;
	logic      slave_sel;
	logic      last_done;

	// Master side at ID_BITS, slave side at IDS_BITS
	axi_ar_if #(.ID_W(ID_BITS))  ar_m0 ();
	axi_ar_if #(.ID_W(ID_BITS))  ar_m1 ();
	axi_ar_if #(.ID_W(IDS_BITS)) ar_s0 ();
	axi_ar_if #(.ID_W(IDS_BITS)) ar_s1 ();
	axi_r_if  #(.ID_W(ID_BITS))  r_m0 ();
	axi_r_if  #(.ID_W(ID_BITS))  r_m1 ();
	axi_r_if  #(.ID_W(IDS_BITS)) r_s0 ();
	axi_r_if  #(.ID_W(IDS_BITS)) r_s1 ();

	//==================================================================
	// Port to interface wiring
	//==================================================================

	assign ar_m0.id    = arid_m0;
	assign ar_m0.addr  = araddr_m0;
	assign ar_m0.len   = arlen_m0;
	assign ar_m0.size  = arsize_m0;
	assign ar_m0.burst = arburst_m0;
	assign ar_m0.valid = arvalid_m0;
	assign arready_m0  = ar_m0.ready;
	assign ar_m1.id    = arid_m1;
	assign ar_m1.addr  = araddr_m1;
	assign ar_m1.len   = arlen_m1;
	assign ar_m1.size  = arsize_m1;
	assign ar_m1.burst = arburst_m1;
	assign ar_m1.valid = arvalid_m1;
	assign arready_m1  = ar_m1.ready;

	assign arid_s0     = ar_s0.id;
	assign araddr_s0   = ar_s0.addr;
	assign arlen_s0    = ar_s0.len;
	assign arsize_s0   = ar_s0.size;
	assign arburst_s0  = ar_s0.burst;
	assign arvalid_s0  = ar_s0.valid;
	assign ar_s0.ready = arready_s0;
	assign arid_s1     = ar_s1.id;
	assign araddr_s1   = ar_s1.addr;
	assign arlen_s1    = ar_s1.len;
	assign arsize_s1   = ar_s1.size;
	assign arburst_s1  = ar_s1.burst;
	assign arvalid_s1  = ar_s1.valid;
	assign ar_s1.ready = arready_s1;

	// R channels
	assign rid_m0     = r_m0.id;
	assign rdata_m0   = r_m0.data;
	assign rresp_m0   = r_m0.resp;
	assign rlast_m0   = r_m0.last;
	assign rvalid_m0  = r_m0.valid;
	assign r_m0.ready = rready_m0;
	assign rid_m1     = r_m1.id;
	assign rdata_m1   = r_m1.data;
	assign rresp_m1   = r_m1.resp;
	assign rlast_m1   = r_m1.last;
	assign rvalid_m1  = r_m1.valid;
	assign r_m1.ready = rready_m1;

	assign r_s0.id    = rid_s0;
	assign r_s0.data  = rdata_s0;
	assign r_s0.resp  = rresp_s0;
	assign r_s0.last  = rlast_s0;
	assign r_s0.valid = rvalid_s0;
	assign rready_s0  = r_s0.ready;
	assign r_s1.id    = rid_s1;
	assign r_s1.data  = rdata_s1;
	assign r_s1.resp  = rresp_s1;
	assign r_s1.last  = rlast_s1;
	assign r_s1.valid = rvalid_s1;
	assign rready_s1  = r_s1.ready;

	//==================================================================
	// Arbiter and routers
	//==================================================================

	// Requests come straight from ARVALID
	rd_arbiter rd_arbiter_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.m0_req      (arvalid_m0),
		.m1_req      (arvalid_m1),
		.addr_accept (addr_accept),
		.slave_sel   (slave_sel),
		.last_done   (last_done),
		.state       (state),
		.grant       (grant),
		.route       (route)
	);

	ar_router ar_router_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.m0          (ar_m0),
		.m1          (ar_m1),
		.s0          (ar_s0),
		.s1          (ar_s1),
		.state       (state),
		.grant       (grant),
		.addr_accept (addr_accept),
		.slave_sel   (slave_sel)
	);

	r_router r_router_i (
		.r_m0      (r_m0),
		.r_m1      (r_m1),
		.r_s0      (r_s0),
		.r_s1      (r_s1),
		.state     (state),
		.grant     (grant),
		.route     (route),
		.last_done (last_done)
	);

endmodule

// ==== design/r_router.sv ====
//======================================================================
// Read data return from routed slave to granted master
//======================================================================
`timescale 1ns/1ps

module r_router (
	axi_r_if.sub                  r_m0,
	axi_r_if.sub                  r_m1,
	axi_r_if.mgr                  r_s0,
	axi_r_if.mgr                  r_s1,
	input  axi_rd_pkg::rd_state_e state,
	input  logic                  grant,
	input  logic                  route,
	output logic                  last_done
);
	import axi_rd_pkg::*;

	// Path open only while a read is in its data phase
	logic                 active;
	ids_t                 s_id;
	data_t                s_data;
	logic [RESP_BITS-1:0] s_resp;
	logic                 s_last;
	logic                 s_valid;
	logic                 m_ready;

	assign active = (state == RD_DATA);

	// Routed slave beat
	assign s_id    = route ? r_s1.id    : r_s0.id;
	assign s_data  = route ? r_s1.data  : r_s0.data;
	assign s_resp  = route ? r_s1.resp  : r_s0.resp;
	assign s_last  = route ? r_s1.last  : r_s0.last;
	assign s_valid = route ? r_s1.valid : r_s0.valid;

	// Granted master RREADY
	assign m_ready = grant ? r_m1.ready : r_m0.ready;

	// Master payload, upper ID bits with the master index dropped
	assign r_m0.id   = s_id[ID_BITS-1:0];
	assign r_m0.data = s_data;
	assign r_m0.resp = s_resp;
	assign r_m0.last = s_last;
	assign r_m1.id   = s_id[ID_BITS-1:0];
	assign r_m1.data = s_data;
	assign r_m1.resp = s_resp;
	assign r_m1.last = s_last;

	assign r_m0.valid = active && !grant && s_valid;
	assign r_m1.valid = active && grant && s_valid;

	assign r_s0.ready = active && !route && m_ready;
	assign r_s1.ready = active && route && m_ready;

	// Final beat taken by the master
	assign last_done = active && s_valid && s_last && m_ready;

endmodule

// ==== design/ar_router.sv ====
//======================================================================
// Read address mux, ID widening, slave decode and hold register
//======================================================================
`timescale 1ns/1ps

module ar_router (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	axi_ar_if.sub                 m0,
	axi_ar_if.sub                 m1,
	axi_ar_if.mgr                 s0,
	axi_ar_if.mgr                 s1,
	input  axi_rd_pkg::rd_state_e state,
	input  logic                  grant,
	output logic                  addr_accept,
	output logic                  slave_sel
);
	import axi_rd_pkg::*;

	// Granted master channel
	id_t                   m_id;
	addr_t                 m_addr;
	logic [LEN_BITS-1:0]   m_len;
	logic [SIZE_BITS-1:0]  m_size;
	logic [BURST_BITS-1:0] m_burst;
	logic                  m_valid;

	// Hold register toward the slaves
	ids_t                  hold_id;
	addr_t                 hold_addr;
	logic [LEN_BITS-1:0]   hold_len;
	logic [SIZE_BITS-1:0]  hold_size;
	logic [BURST_BITS-1:0] hold_burst;
	logic                  hold_valid;
	logic                  hold_sel;
	logic                  s_ready;

	//==================================================================
	// Master side
	//==================================================================

	assign m_id    = grant ? m1.id    : m0.id;
	assign m_addr  = grant ? m1.addr  : m0.addr;
	assign m_len   = grant ? m1.len   : m0.len;
	assign m_size  = grant ? m1.size  : m0.size;
	assign m_burst = grant ? m1.burst : m0.burst;
	assign m_valid = grant ? m1.valid : m0.valid;

	// ARREADY to granted master, one cycle in RD_ADDR
	assign m0.ready = (state == RD_ADDR) && !grant;
	assign m1.ready = (state == RD_ADDR) && grant;

	assign addr_accept = (state == RD_ADDR) && m_valid;
	// Address decode, every address hits a slave
	assign slave_sel   = m_addr[SLAVE_SEL_BIT];

	//==================================================================
	// Hold register
	//==================================================================

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			hold_valid <= 1'b0;
			hold_sel   <= 1'b0;
		end else if (addr_accept) begin
			hold_valid <= 1'b1;
			hold_sel   <= slave_sel;
		end else if (hold_valid && s_ready) begin
			hold_valid <= 1'b0;
		end
	end

	// Payload, loaded once per read, kept through slave stalls
	always_ff @(posedge ACLK) begin
		if (addr_accept) begin
			hold_id    <= {{(IDS_BITS-ID_BITS-1){1'b0}}, grant, m_id};
			hold_addr  <= m_addr;
			hold_len   <= m_len;
			hold_size  <= m_size;
			hold_burst <= m_burst;
		end
	end

	assign s_ready = hold_sel ? s1.ready : s0.ready;

	// Only the selected slave sees the request
	assign s0.valid = hold_valid && !hold_sel;
	assign s0.id    = hold_sel ? '0 : hold_id;
	assign s0.addr  = hold_sel ? '0 : hold_addr;
	assign s0.len   = hold_sel ? '0 : hold_len;
	assign s0.size  = hold_sel ? '0 : hold_size;
	assign s0.burst = hold_sel ? '0 : hold_burst;

	assign s1.valid = hold_valid && hold_sel;
	assign s1.id    = hold_sel ? hold_id    : '0;
	assign s1.addr  = hold_sel ? hold_addr  : '0;
	assign s1.len   = hold_sel ? hold_len   : '0;
	assign s1.size  = hold_sel ? hold_size  : '0;
	assign s1.burst = hold_sel ? hold_burst : '0;

endmodule

// ==== design/rd_arbiter.sv ====
//======================================================================
// Round-robin read arbiter with grant/route register and FSM
//======================================================================
`timescale 1ns/1ps

module rd_arbiter (
	input  logic                  ACLK,
	input  logic                  ARESETn,
	input  logic                  m0_req,
	input  logic                  m1_req,
	input  logic                  addr_accept,
	input  logic                  slave_sel,
	input  logic                  last_done,
	output axi_rd_pkg::rd_state_e state,
	output logic                  grant,
	output logic                  route
);
	import axi_rd_pkg::*;

	// Master holding priority when both request, 0 means m0
	logic prio;
	// Master picked in idle
	logic pick;
	rd_state_e state_nx;

	//==================================================================
	// Pick logic
	//==================================================================

	always_comb begin
		if (m0_req && m1_req) begin
			pick = prio;
		end else begin
			// Lone requester wins, m0 if nobody asks
			pick = m1_req;
		end
	end

	// Next state
	always_comb begin
		state_nx = state;
		case (state)
			RD_IDLE: begin
				if (m0_req || m1_req) begin
					state_nx = RD_ADDR;
				end
			end
			RD_ADDR: begin
				// Slave side valid is held by the AR router from here
				if (addr_accept) begin
					state_nx = RD_DATA;
				end
			end
			RD_DATA: begin
				if (last_done) begin
					state_nx = RD_IDLE;
				end
			end
			default: state_nx = RD_IDLE;
		endcase
	end

	//==================================================================
	// State, grant, route and priority registers
	//==================================================================

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state <= RD_IDLE;
			grant <= 1'b0;
			route <= 1'b0;
			prio  <= 1'b0;
		end else begin
			state <= state_nx;
			// Grant latched once, kept until the last beat
			if (state == RD_IDLE && (m0_req || m1_req)) begin
				grant <= pick;
			end
			// Target slave captured with the address
			if (state == RD_ADDR && addr_accept) begin
				route <= slave_sel;
			end
			// Other master goes first next time
			if (state == RD_DATA && last_done) begin
				prio <= ~grant;
			end
		end
	end

endmodule

// ==== design/axi_r_if.sv ====
//======================================================================
// AXI read data channel, master and slave side modports
//======================================================================
`timescale 1ns/1ps

interface axi_r_if #(
	parameter int ID_W = axi_rd_pkg::ID_BITS
);
	import axi_rd_pkg::*;

	logic [ID_W-1:0]      id;
	data_t                data;
	logic [RESP_BITS-1:0] resp;
	logic                 last;
	logic                 valid;
	logic                 ready;

	// Beat source, i.e. the slave end
	modport sub (
		output id, data, resp, last, valid,
		input  ready
	);

	// Beat sink, drives RREADY only
	modport mgr (
		input  id, data, resp, last, valid,
		output ready
	);

endinterface

// ==== design/axi_ar_if.sv ====
//======================================================================
// AXI read address channel, master and slave side modports
//======================================================================
`timescale 1ns/1ps

interface axi_ar_if #(
	parameter int ID_W = axi_rd_pkg::ID_BITS
);
	import axi_rd_pkg::*;

	logic [ID_W-1:0]       id;
	addr_t                 addr;
	logic [LEN_BITS-1:0]   len;
	logic [SIZE_BITS-1:0]  size;
	logic [BURST_BITS-1:0] burst;
	logic                  valid;
	logic                  ready;

	// Issuing side
	modport mgr (
		output id, addr, len, size, burst, valid,
		input  ready
	);

	// Accepting side
	modport sub (
		input  id, addr, len, size, burst, valid,
		output ready
	);

endinterface

// ==== design/axi_rd_pkg.sv ====
//======================================================================
// Shared widths, address map, ID types and arbiter states
// for the read crossbar
//======================================================================

package axi_rd_pkg;

	// Bus widths
	localparam int ADDR_BITS  = 32;
	localparam int DATA_BITS  = 32;
	localparam int ID_BITS    = 4;
	// Slave side ID, master index in bit 4, upper bits zero
	localparam int IDS_BITS   = 8;
	localparam int LEN_BITS   = 4;
	localparam int SIZE_BITS  = 3;
	localparam int BURST_BITS = 2;
	localparam int RESP_BITS  = 2;

	// Address map, one bit picks the slave
	localparam int SLAVE_SEL_BIT = 16;

	// Read response codes
	localparam logic [RESP_BITS-1:0] RESP_OKAY   = 2'b00;
	localparam logic [RESP_BITS-1:0] RESP_SLVERR = 2'b10;

	typedef logic [ID_BITS-1:0]   id_t;
	typedef logic [IDS_BITS-1:0]  ids_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [DATA_BITS-1:0] data_t;

	// Read transaction states
	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_ADDR = 2'd1,
		RD_DATA = 2'd2
	} rd_state_e;

endpackage
